// File: hdl/mem_unit_cfg.svh
// Size constants for the load/store memory unit
// Include this wherever a port or signal width depends on the memory geometry

`ifndef MEM_UNIT_CFG_SVH
`define MEM_UNIT_CFG_SVH

// Width of one memory word in bits
`define MEM_DATA_NBITS 32

// Number of words held in the SRAM
`define MEM_NUM_ENTRIES 64

// Byte address width, which is the word index plus two byte offset bits
`define MEM_ADDR_NBITS 8

`endif

// File: hdl/mem_unit_pkg.sv
// Shared types for the load/store memory unit
// Modules refer to these by scoped name and never import the package

package mem_unit_pkg;

  // ------------------------------------------------
  // Request opcodes
  // ------------------------------------------------

  // Loads come first and stores last, so the three store codes share
  // the two top values of the encoding plus OP_SW
  typedef enum logic [2:0] {
    // Load a full word, address must be word aligned
    OP_LW  = 3'd0,
    // Load a halfword and sign extend it
    OP_LH  = 3'd1,
    // Load a halfword and zero extend it
    OP_LHU = 3'd2,
    // Load a byte and sign extend it
    OP_LB  = 3'd3,
    // Load a byte and zero extend it
    OP_LBU = 3'd4,
    // Store a full word
    OP_SW  = 3'd5,
    // Store the low halfword of the store data
    OP_SH  = 3'd6,
    // Store the low byte of the store data
    OP_SB  = 3'd7
  } mem_op_e;

endpackage

// File: hdl/sram_sync_1rw.sv
// Single-port synchronous SRAM with a registered read and byte write enables
// The array is split into one narrow memory per byte lane so each lane
// writes independently

`timescale 1ns/1ps

module sram_sync_1rw #(
  parameter int data_nbits  = 32,
  parameter int num_entries = 64
) (
  input  logic                          clk,
  input  logic                          read_en,
  input  logic [$clog2(num_entries)-1:0] addr,
  output logic [data_nbits-1:0]         read_data,
  input  logic                          write_en,
  input  logic [(data_nbits+7)/8-1:0]   write_byte_en,
  input  logic [data_nbits-1:0]         write_data
);

  // Number of byte lanes, the last one may be narrower than 8 bits
  localparam int data_nbytes = (data_nbits + 7) / 8;

  // ------------------------------------------------
  // Per-lane storage
  // ------------------------------------------------

  // Each lane owns its slice of the word and its own read register.
  // There is only one address, shared by reads and writes, so a caller
  // must never raise read_en and write_en in the same cycle
  for (genvar i = 0; i < data_nbytes; i++) begin : g_lane
    // Bit offset and width of this lane inside the word
    localparam int lo    = i * 8;
    localparam int width = (data_nbits - lo < 8) ? (data_nbits - lo) : 8;

    logic [width-1:0] lane_mem [num_entries];
    logic [width-1:0] lane_rdata;

    // A write only touches this lane when its byte enable is set
    always_ff @(posedge clk) begin
      if (write_en && write_byte_en[i]) begin
        lane_mem[addr] <= write_data[lo +: width];
      end
    end

    // Read data appears after the edge that samples read_en.
    // With read_en low the register keeps stale contents, which the
    // consumer must treat as undefined
    always_ff @(posedge clk) begin
      if (read_en) begin
        lane_rdata <= lane_mem[addr];
      end
    end

    assign read_data[lo +: width] = lane_rdata;
  end

endmodule

// File: hdl/mem_decode.sv
// Decode stage of the memory unit
// Registers each request with its word address, byte enables, lane-shifted
// store data and misalignment flag for the execute stage

`timescale 1ns/1ps
`include "mem_unit_cfg.svh"

module mem_decode (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             cmd_valid,
  input  mem_unit_pkg::mem_op_e            cmd_op,
  input  logic [`MEM_ADDR_NBITS-1:0]       cmd_addr,
  input  logic [`MEM_DATA_NBITS-1:0]       cmd_data,
  output logic                             d_valid,
  output mem_unit_pkg::mem_op_e            d_op,
  output logic [`MEM_ADDR_NBITS-3:0]       d_word_addr,
  output logic [1:0]                       d_lane,
  output logic [`MEM_DATA_NBITS/8-1:0]     d_byte_en,
  output logic [`MEM_DATA_NBITS-1:0]       d_wdata,
  output logic                             d_err
);

  logic                         misaligned;
  logic [`MEM_DATA_NBITS/8-1:0] byte_en;
  logic [`MEM_DATA_NBITS-1:0]   wdata;

  // ------------------------------------------------
  // Size decode and alignment check
  // ------------------------------------------------

  // The access size follows from the opcode alone, loads and stores of
  // the same size share one branch
  always_comb begin
    misaligned = 1'b0;
    byte_en    = 4'b1111;
    wdata      = cmd_data;
    case (cmd_op)
      mem_unit_pkg::OP_LW,
      mem_unit_pkg::OP_SW: begin
        // Words need both low address bits clear
        misaligned = |cmd_addr[1:0];
      end
      mem_unit_pkg::OP_LH,
      mem_unit_pkg::OP_LHU,
      mem_unit_pkg::OP_SH: begin
        misaligned = cmd_addr[0];
        byte_en    = cmd_addr[1] ? 4'b1100 : 4'b0011;
        // The halfword is copied into both halves so either lane sees it
        wdata      = {2{cmd_data[15:0]}};
      end
      default: begin
        // Byte accesses are always aligned
        byte_en = 4'b0001 << cmd_addr[1:0];
        wdata   = {4{cmd_data[7:0]}};
      end
    endcase
    // A misaligned request must leave memory untouched, so its enables
    // are cleared here as well as being gated in execute
    if (misaligned) begin
      byte_en = '0;
    end
  end

  // ------------------------------------------------
  // Stage registers
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      d_valid <= 1'b0;
    end else begin
      d_valid <= cmd_valid;
    end
  end

  // The payload is only captured for a real request, downstream logic
  // qualifies every field with d_valid
  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      d_op        <= cmd_op;
      d_word_addr <= cmd_addr[`MEM_ADDR_NBITS-1:2];
      d_lane      <= cmd_addr[1:0];
      d_byte_en   <= byte_en;
      d_wdata     <= wdata;
      d_err       <= misaligned;
    end
  end

endmodule

// File: hdl/mem_execute.sv
// Execute stage of the memory unit
// Drives the SRAM from the decoded request and carries the op, lane and
// error flag forward so they line up with the SRAM read data

`timescale 1ns/1ps
`include "mem_unit_cfg.svh"

module mem_execute (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         d_valid,
  input  mem_unit_pkg::mem_op_e        d_op,
  input  logic [`MEM_ADDR_NBITS-3:0]   d_word_addr,
  input  logic [1:0]                   d_lane,
  input  logic [`MEM_DATA_NBITS/8-1:0] d_byte_en,
  input  logic [`MEM_DATA_NBITS-1:0]   d_wdata,
  input  logic                         d_err,
  output logic [`MEM_DATA_NBITS-1:0]   read_data,
  output logic                         x_valid,
  output mem_unit_pkg::mem_op_e        x_op,
  output logic [1:0]                   x_lane,
  output logic                         x_err
);

  logic is_store;
  logic read_en;
  logic write_en;

  // ------------------------------------------------
  // SRAM port control
  // ------------------------------------------------

  // Every opcode that is not a store is a load
  assign is_store = (d_op == mem_unit_pkg::OP_SW) ||
                    (d_op == mem_unit_pkg::OP_SH) ||
                    (d_op == mem_unit_pkg::OP_SB);

  // Only one request sits in this stage, so a read and a write can
  // never be requested in the same cycle
  assign read_en  = d_valid && !d_err && !is_store;
  assign write_en = d_valid && !d_err && is_store;

  // Stores land on this edge, loads get their data after it
  sram_sync_1rw #(
    .data_nbits  (`MEM_DATA_NBITS),
    .num_entries (`MEM_NUM_ENTRIES)
  ) u_sram (
    .clk           (clk),
    .read_en       (read_en),
    .addr          (d_word_addr),
    .read_data     (read_data),
    .write_en      (write_en),
    .write_byte_en (d_byte_en),
    .write_data    (d_wdata)
  );

  // ------------------------------------------------
  // Side-band pipeline
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x_valid <= 1'b0;
    end else begin
      x_valid <= d_valid;
    end
  end

  // These follow the request by one stage, matching the SRAM read latency
  always_ff @(posedge clk) begin
    if (d_valid) begin
      x_op   <= d_op;
      x_lane <= d_lane;
      x_err  <= d_err;
    end
  end

endmodule

// File: hdl/mem_result.sv
// Result stage of the memory unit
// Picks the addressed lanes of the read word, extends them and registers
// the one-cycle response

`timescale 1ns/1ps
`include "mem_unit_cfg.svh"

module mem_result (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       x_valid,
  input  mem_unit_pkg::mem_op_e      x_op,
  input  logic [1:0]                 x_lane,
  input  logic                       x_err,
  input  logic [`MEM_DATA_NBITS-1:0] read_data,
  output logic                       rsp_valid,
  output logic [`MEM_DATA_NBITS-1:0] rsp_data,
  output logic                       rsp_err
);

  logic [`MEM_DATA_NBITS-1:0] shifted;
  logic [`MEM_DATA_NBITS-1:0] load_data;

  // ------------------------------------------------
  // Lane select and extension
  // ------------------------------------------------

  // Moving the addressed byte to bit 0 also serves halfwords, since an
  // aligned halfword starts at lane 0 or lane 2
  assign shifted = read_data >> {x_lane, 3'b000};

  always_comb begin
    case (x_op)
      mem_unit_pkg::OP_LW:  load_data = read_data;
      mem_unit_pkg::OP_LH:  load_data = {{(`MEM_DATA_NBITS-16){shifted[15]}}, shifted[15:0]};
      mem_unit_pkg::OP_LHU: load_data = {{(`MEM_DATA_NBITS-16){1'b0}}, shifted[15:0]};
      mem_unit_pkg::OP_LB:  load_data = {{(`MEM_DATA_NBITS-8){shifted[7]}}, shifted[7:0]};
      mem_unit_pkg::OP_LBU: load_data = {{(`MEM_DATA_NBITS-8){1'b0}}, shifted[7:0]};
      // Stores return zero data
      default:              load_data = '0;
    endcase
  end

  // ------------------------------------------------
  // Response register
  // ------------------------------------------------

  // Outside a response the data and error stay at zero, and an errored
  // load never exposes the stale SRAM read register
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
      rsp_data  <= '0;
      rsp_err   <= 1'b0;
    end else begin
      rsp_valid <= x_valid;
      rsp_err   <= x_valid && x_err;
      rsp_data  <= (x_valid && !x_err) ? load_data : '0;
    end
  end

endmodule

// File: hdl/mem_unit_top.sv
// Top level of the load/store memory unit
// One request per clock enters on cmd_*, and its response leaves on rsp_*
// three edges later, in request order

`timescale 1ns/1ps
`include "mem_unit_cfg.svh"

module mem_unit_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cmd_valid,
  input  mem_unit_pkg::mem_op_e      cmd_op,
  input  logic [`MEM_ADDR_NBITS-1:0] cmd_addr,
  input  logic [`MEM_DATA_NBITS-1:0] cmd_data,
  output logic                       rsp_valid,
  output logic [`MEM_DATA_NBITS-1:0] rsp_data,
  output logic                       rsp_err
);

  // ------------------------------------------------
  // Decode to execute
  // ------------------------------------------------

  logic                         d_valid;
  mem_unit_pkg::mem_op_e        d_op;
  logic [`MEM_ADDR_NBITS-3:0]   d_word_addr;
  logic [1:0]                   d_lane;
  logic [`MEM_DATA_NBITS/8-1:0] d_byte_en;
  logic [`MEM_DATA_NBITS-1:0]   d_wdata;
  logic                         d_err;

  // ------------------------------------------------
  // Execute to result
  // ------------------------------------------------

  logic [`MEM_DATA_NBITS-1:0]   read_data;
  logic                         x_valid;
  mem_unit_pkg::mem_op_e        x_op;
  logic [1:0]                   x_lane;
  logic                         x_err;

  mem_decode u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd_op      (cmd_op),
    .cmd_addr    (cmd_addr),
    .cmd_data    (cmd_data),
    .d_valid     (d_valid),
    .d_op        (d_op),
    .d_word_addr (d_word_addr),
    .d_lane      (d_lane),
    .d_byte_en   (d_byte_en),
    .d_wdata     (d_wdata),
    .d_err       (d_err)
  );

  // The SRAM lives inside execute as u_sram
  mem_execute u_execute (
    .clk         (clk),
    .rst_n       (rst_n),
    .d_valid     (d_valid),
    .d_op        (d_op),
    .d_word_addr (d_word_addr),
    .d_lane      (d_lane),
    .d_byte_en   (d_byte_en),
    .d_wdata     (d_wdata),
    .d_err       (d_err),
    .read_data   (read_data),
    .x_valid     (x_valid),
    .x_op        (x_op),
    .x_lane      (x_lane),
    .x_err       (x_err)
  );

  mem_result u_result (
    .clk       (clk),
    .rst_n     (rst_n),
    .x_valid   (x_valid),
    .x_op      (x_op),
    .x_lane    (x_lane),
    .x_err     (x_err),
    .read_data (read_data),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data),
    .rsp_err   (rsp_err)
  );

endmodule

// File: bench/mem_unit_chk.sv
// Bound assertions for the memory unit, attached to every mem_unit_top
// Watch SRAM port use, error gating of writes and the fixed response latency

`timescale 1ns/1ps

module mem_unit_chk (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  cmd_valid,
  input mem_unit_pkg::mem_op_e cmd_op,
  input logic [1:0]            cmd_offset,
  input logic                  rsp_valid,
  input logic                  read_en,
  input logic                  write_en
);

  // Number of assertion failures, read by the testbench at the end
  int fail_count;

  // Offset bits that must be clear for the size of the command's access
  logic [1:0] size_mask;
  logic       cmd_store;
  logic       cmd_misaligned;

  initial begin
    fail_count = 0;
  end

  // Only the three store opcodes write the SRAM
  assign cmd_store = cmd_op inside {mem_unit_pkg::OP_SW, mem_unit_pkg::OP_SH,
                                    mem_unit_pkg::OP_SB};

  always_comb begin
    case (cmd_op)
      mem_unit_pkg::OP_LW, mem_unit_pkg::OP_SW: size_mask = 2'b11;
      mem_unit_pkg::OP_LH, mem_unit_pkg::OP_LHU, mem_unit_pkg::OP_SH: size_mask = 2'b01;
      default: size_mask = 2'b00;
    endcase
  end

  assign cmd_misaligned = |(cmd_offset & size_mask);

  // An SRAM access belongs to the request sampled one edge before.
  // It is a read or a write but never both, and it writes only for a store
  one_port_access: assert property (@(posedge clk) disable iff (!rst_n)
    (read_en || write_en) |-> (read_en != write_en) && $past(cmd_valid) &&
                              (write_en == $past(cmd_store)))
  else begin
    fail_count++;
    $error("SRAM access does not match the request one edge earlier");
  end

  // A misaligned request sampled at edge E must not write at edge E+1
  no_write_on_error: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid && cmd_misaligned |=> !write_en)
  else begin
    fail_count++;
    $error("SRAM write_en is high for a misaligned request");
  end

  // A request sampled at edge E shows its response at edge E+3
  fixed_latency: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid == $past(cmd_valid, 3))
  else begin
    fail_count++;
    $error("rsp_valid does not follow cmd_valid by three edges");
  end

endmodule

// The SRAM port signals are reached through the execute stage
bind mem_unit_top mem_unit_chk u_chk (
  .clk        (clk),
  .rst_n      (rst_n),
  .cmd_valid  (cmd_valid),
  .cmd_op     (cmd_op),
  .cmd_offset (cmd_addr[1:0]),
  .rsp_valid  (rsp_valid),
  .read_en    (u_execute.u_sram.read_en),
  .write_en   (u_execute.u_sram.write_en)
);

// File: bench/mem_unit_mon.sv
// Response checker for the memory unit testbench
// Keeps a byte model of memory, predicts every response and compares it

`timescale 1ns/1ps
`include "mem_unit_cfg.svh"

module mem_unit_mon (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cmd_valid,
  input  mem_unit_pkg::mem_op_e      cmd_op,
  input  logic [`MEM_ADDR_NBITS-1:0] cmd_addr,
  input  logic [`MEM_DATA_NBITS-1:0] cmd_data,
  input  logic                       rsp_valid,
  input  logic [`MEM_DATA_NBITS-1:0] rsp_data,
  input  logic                       rsp_err,
  output int                         error_count,
  output int                         check_count,
  output int                         pending
);

  // Little-endian byte model, one entry per byte address
  logic [7:0] model [2**`MEM_ADDR_NBITS];

  // Expected responses in request order, with the cycle each one is due
  logic [`MEM_DATA_NBITS-1:0] exp_data_q [$];
  logic                       exp_err_q [$];
  mem_unit_pkg::mem_op_e      op_q [$];
  logic [`MEM_ADDR_NBITS-1:0] addr_q [$];
  longint                     due_q [$];
  longint                     cycle;

  initial begin
    error_count = 0;
    check_count = 0;
    pending     = 0;
    cycle       = 0;
  end

  // ------------------------------------------------
  // Prediction from the access rules
  // ------------------------------------------------

  task automatic predict(
    input  mem_unit_pkg::mem_op_e      op,
    input  logic [`MEM_ADDR_NBITS-1:0] addr,
    input  logic [`MEM_DATA_NBITS-1:0] data,
    output logic [`MEM_DATA_NBITS-1:0] exp_data,
    output logic                       exp_err
  );
    int                         nbytes;
    logic                       is_store;
    logic [`MEM_ADDR_NBITS-1:0] idx;
    logic [`MEM_DATA_NBITS-1:0] value;
    case (op)
      mem_unit_pkg::OP_LW, mem_unit_pkg::OP_SW: nbytes = 4;
      mem_unit_pkg::OP_LH, mem_unit_pkg::OP_LHU, mem_unit_pkg::OP_SH: nbytes = 2;
      default: nbytes = 1;
    endcase
    is_store = op inside {mem_unit_pkg::OP_SW, mem_unit_pkg::OP_SH, mem_unit_pkg::OP_SB};
    // An access is aligned when its address is a multiple of its size
    exp_err  = (int'(addr) % nbytes) != 0;
    exp_data = '0;
    value    = '0;
    if (!exp_err) begin
      for (int i = 0; i < nbytes; i++) begin
        idx = addr + `MEM_ADDR_NBITS'(i);
        if (is_store) begin
          model[idx] = data[8*i +: 8];
        end else begin
          value[8*i +: 8] = model[idx];
        end
      end
      // Unsigned loads are already zero filled above the loaded bytes
      case (op)
        mem_unit_pkg::OP_LW:  exp_data = value;
        mem_unit_pkg::OP_LHU: exp_data = value;
        mem_unit_pkg::OP_LBU: exp_data = value;
        mem_unit_pkg::OP_LH:  exp_data = `MEM_DATA_NBITS'($signed(value[15:0]));
        mem_unit_pkg::OP_LB:  exp_data = `MEM_DATA_NBITS'($signed(value[7:0]));
        default:              exp_data = '0;
      endcase
    end
  endtask

  // ------------------------------------------------
  // Sampling and comparison
  // ------------------------------------------------

  // Both sides are sampled mid-cycle, where inputs and outputs are stable.
  // A request seen here has its response visible three falling edges later
  always @(negedge clk) begin
    logic [`MEM_DATA_NBITS-1:0] exp_data;
    logic                       exp_err;
    mem_unit_pkg::mem_op_e      op;
    if (rst_n) begin
      cycle++;
      if (due_q.size() > 0 && due_q[0] == cycle) begin
        op = op_q[0];
        if (!rsp_valid) begin
          $display("missing response for %s at address 0x%02h", op.name(), addr_q[0]);
          error_count++;
        end else begin
          check_count++;
          if (rsp_err !== exp_err_q[0]) begin
            $display("CHECK FAILED rsp_err: expected 0x%01h, got 0x%01h (%s addr 0x%02h)",
                     exp_err_q[0], rsp_err, op.name(), addr_q[0]);
            error_count++;
          end
          if (rsp_data !== exp_data_q[0]) begin
            $display("CHECK FAILED rsp_data: expected 0x%08h, got 0x%08h (%s addr 0x%02h)",
                     exp_data_q[0], rsp_data, op.name(), addr_q[0]);
            error_count++;
          end
        end
        void'(exp_data_q.pop_front());
        void'(exp_err_q.pop_front());
        void'(op_q.pop_front());
        void'(addr_q.pop_front());
        void'(due_q.pop_front());
      end else if (rsp_valid) begin
        $display("a response arrived on a cycle where none was expected");
        error_count++;
      end
      // The model moves in request order, so a load sees every older store
      if (cmd_valid) begin
        predict(cmd_op, cmd_addr, cmd_data, exp_data, exp_err);
        exp_data_q.push_back(exp_data);
        exp_err_q.push_back(exp_err);
        op_q.push_back(cmd_op);
        addr_q.push_back(cmd_addr);
        due_q.push_back(cycle + 3);
      end
      pending = due_q.size();
    end
  end

endmodule

// File: bench/mem_unit_tb.sv
// Top-level testbench for the memory unit
// Runs five directed random tests, checked by the monitor and bound assertions

`timescale 1ns/1ps
`include "mem_unit_cfg.svh"

module mem_unit_tb;

  localparam int clk_period = 100;
  localparam int word_nbits = `MEM_ADDR_NBITS - 2;
  localparam int num_words  = `MEM_NUM_ENTRIES;
  localparam int t2_stores  = 64;
  localparam int t4_bad     = 48;
  localparam int t5_reqs    = 200;
  // Requests per test, each test issues one per cycle
  localparam int total_reqs = 2 * num_words + (t2_stores + num_words) + 12 * num_words +
                              (t4_bad + num_words) + t5_reqs;

  logic                       clk;
  logic                       rst_n;
  logic                       cmd_valid;
  mem_unit_pkg::mem_op_e      cmd_op;
  logic [`MEM_ADDR_NBITS-1:0] cmd_addr;
  logic [`MEM_DATA_NBITS-1:0] cmd_data;
  logic                       rsp_valid;
  logic [`MEM_DATA_NBITS-1:0] rsp_data;
  logic                       rsp_err;
  int                         error_count;
  int                         check_count;
  int                         pending;
  logic [31:0]                lfsr_state;
  int                         tb_errors;
  int                         tests_failed;

  mem_unit_top dut (.*);

  mem_unit_mon u_mon (.*);

  initial begin
    clk = 1'b0;
  end

  always #(clk_period / 2) clk = ~clk;

  // ------------------------------------------------
  // Stimulus helpers
  // ------------------------------------------------

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // Holds one request for one clock, then returns 1 ns after the edge
  task automatic send(input mem_unit_pkg::mem_op_e op, input logic [word_nbits-1:0] word,
                      input logic [1:0] lane, input logic [`MEM_DATA_NBITS-1:0] data);
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_addr  = {word, lane};
    cmd_data  = data;
    @(posedge clk);
    #1;
  endtask

  function automatic int total_errors();
    return error_count + tb_errors;
  endfunction

  // Stops issuing and waits for the monitor to retire every response
  task automatic drain();
    int waited;
    waited    = 0;
    cmd_valid = 1'b0;
    while (pending != 0 && waited < 8) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (pending != 0) begin
      $display("%0d responses still outstanding after %0d idle cycles", pending, waited);
      tb_errors++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    int found;
    drain();
    found = total_errors() - errors_before;
    if (found == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, found);
      tests_failed++;
    end
  endtask

  task automatic load_all_words();
    for (int w = 0; w < num_words; w++) begin
      send(mem_unit_pkg::OP_LW, word_nbits'(w), 2'd0, '0);
    end
  endtask

  // ------------------------------------------------
  // Watchdog
  // ------------------------------------------------

  // Drains add about three idle cycles per test on top of the requests
  initial begin
    wait (rst_n === 1'b1);
    repeat (total_reqs + 20) @(posedge clk);
    $display("timeout after %0d cycles, the run did not complete", total_reqs + 20);
    $display("tests failed");
    $finish;
  end

  // ------------------------------------------------
  // Test sequence
  // ------------------------------------------------

  initial begin
    logic [31:0]           r;
    logic [31:0]           d;
    logic [31:0]           w;
    logic [31:0]           l;
    logic [31:0]           m;
    mem_unit_pkg::mem_op_e op;
    logic                  prev_store;
    logic [word_nbits-1:0] prev_word;
    int                    start;
    int                    all_errors;
    rst_n        = 1'b0;
    cmd_valid    = 1'b0;
    cmd_op       = mem_unit_pkg::OP_LW;
    cmd_addr     = '0;
    cmd_data     = '0;
    lfsr_state   = 32'h1edc_2c97;
    tb_errors    = 0;
    tests_failed = 0;
    prev_store   = 1'b0;
    prev_word    = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Every word gets a known value before anything reads it
    start = total_errors();
    for (int i = 0; i < num_words; i++) begin
      take_bits(32, d);
      send(mem_unit_pkg::OP_SW, word_nbits'(i), 2'd0, d);
    end
    load_all_words();
    report_test("test 1 word round trip", start);

    start = total_errors();
    for (int i = 0; i < t2_stores; i++) begin
      take_bits(1, r);
      take_bits(word_nbits, w);
      take_bits(2, l);
      take_bits(32, d);
      if (r[0]) begin
        send(mem_unit_pkg::OP_SH, w[word_nbits-1:0], {l[1], 1'b0}, d);
      end else begin
        send(mem_unit_pkg::OP_SB, w[word_nbits-1:0], l[1:0], d);
      end
    end
    load_all_words();
    report_test("test 2 byte and halfword stores", start);

    start = total_errors();
    for (int i = 0; i < num_words; i++) begin
      for (int k = 0; k < 4; k++) begin
        send(mem_unit_pkg::OP_LB, word_nbits'(i), 2'(k), '0);
        send(mem_unit_pkg::OP_LBU, word_nbits'(i), 2'(k), '0);
        if (k % 2 == 0) begin
          send(mem_unit_pkg::OP_LH, word_nbits'(i), 2'(k), '0);
          send(mem_unit_pkg::OP_LHU, word_nbits'(i), 2'(k), '0);
        end
      end
    end
    report_test("test 3 sign and zero extension", start);

    // Halfwords get an odd lane, words any nonzero lane
    start = total_errors();
    for (int i = 0; i < t4_bad; i++) begin
      take_bits(3, r);
      take_bits(word_nbits, w);
      take_bits(2, l);
      take_bits(32, d);
      case (int'(r[2:0]) % 5)
        0: op = mem_unit_pkg::OP_LH;
        1: op = mem_unit_pkg::OP_LHU;
        2: op = mem_unit_pkg::OP_SH;
        3: op = mem_unit_pkg::OP_LW;
        default: op = mem_unit_pkg::OP_SW;
      endcase
      if (op == mem_unit_pkg::OP_LW || op == mem_unit_pkg::OP_SW) begin
        l[1:0] = (l[1:0] == 2'd0) ? 2'd3 : l[1:0];
      end else begin
        l[0] = 1'b1;
      end
      send(op, w[word_nbits-1:0], l[1:0], d);
    end
    load_all_words();
    report_test("test 4 misaligned requests", start);

    // Mostly aligned traffic, with a load of the same word after some stores
    start = total_errors();
    for (int i = 0; i < t5_reqs; i++) begin
      take_bits(3, r);
      take_bits(word_nbits, w);
      take_bits(2, l);
      take_bits(32, d);
      take_bits(3, m);
      op = mem_unit_pkg::mem_op_e'(r[2:0]);
      if (prev_store && m[0]) begin
        op        = mem_unit_pkg::OP_LW;
        w[word_nbits-1:0] = prev_word;
        l[1:0]    = 2'd0;
      end else if (m[2:1] != 2'd0) begin
        if (op == mem_unit_pkg::OP_LW || op == mem_unit_pkg::OP_SW) begin
          l[1:0] = 2'd0;
        end else if (op inside {mem_unit_pkg::OP_LH, mem_unit_pkg::OP_LHU,
                                mem_unit_pkg::OP_SH}) begin
          l[0] = 1'b0;
        end
      end
      send(op, w[word_nbits-1:0], l[1:0], d);
      prev_store = op inside {mem_unit_pkg::OP_SW, mem_unit_pkg::OP_SH, mem_unit_pkg::OP_SB};
      prev_word  = w[word_nbits-1:0];
    end
    report_test("test 5 back-to-back mixed traffic", start);

    all_errors = total_errors() + dut.u_chk.fail_count;
    $display("tests: 5, failed: %0d, responses checked: %0d, errors: %0d, assertion failures: %0d",
             tests_failed, check_count, all_errors, dut.u_chk.fail_count);
    if (tests_failed == 0 && all_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+hdl
hdl/mem_unit_pkg.sv
hdl/sram_sync_1rw.sv
hdl/mem_decode.sv
hdl/mem_execute.sv
hdl/mem_result.sv
hdl/mem_unit_top.sv
bench/mem_unit_chk.sv
bench/mem_unit_mon.sv
bench/mem_unit_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the memory unit testbench with Verilator, then check the log
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert -f src.f --top-module mem_unit_tb -o sim_mem_unit \
  > build.log 2>&1 &&
./obj_dir/sim_mem_unit > sim.log 2>&1
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
